//--- design/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    // addi x0, x0, 0.
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
        alu_sltu, alu_sll, alu_srl, alu_sra, alu_pass_b
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jal, br_jalr
    } branch_e;

    typedef enum logic {asrc_rs1, asrc_pc} asrc_e;
    typedef enum logic [1:0] {bsrc_rs2, bsrc_imm, bsrc_four} bsrc_e;
    typedef enum logic [1:0] {fwd_reg, fwd_mem, fwd_wb} fwd_e;
    typedef enum logic [1:0] {ctl_run, ctl_pause, ctl_flush} stage_ctl_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_instr_u;

    typedef struct packed {
        logic    regwr;
        logic    mem_to_reg;
        logic    memwr;
        asrc_e   asrc;
        bsrc_e   bsrc;
        alu_op_e alu_op;
        branch_e branch;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        rv_instr_u       instr;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        ctrl_t                 ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       target_pc;
        logic [xlen-1:0]       target_rs1;
        logic                  less;
        logic                  zero;
        logic [reg_addr_w-1:0] rd;
        ctrl_t                 ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       load_data;
        logic [reg_addr_w-1:0] rd;
        logic                  regwr;
        logic                  mem_to_reg;
    } mem_wb_t;

endpackage

//--- design/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic               clk,
    input  logic               rst_n,
    input  rv_pkg::stage_ctl_e ctl,
    input  payload_t           d,
    output payload_t           q
);

    // an all-zero payload is a bubble.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else begin
            case (ctl)
                rv_pkg::ctl_flush: q <= '0;
                rv_pkg::ctl_pause: q <= q;
                default:           q <= d;
            endcase
        end
    end

endmodule

//--- design/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  rv_pkg::rv_instr_u           instr,
    output rv_pkg::ctrl_t               ctrl,
    output logic [rv_pkg::xlen-1:0]     imm
);

    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  return rv_pkg::alu_sll;
            3'b010:  return rv_pkg::alu_slt;
            3'b011:  return rv_pkg::alu_sltu;
            3'b100:  return rv_pkg::alu_xor;
            3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  return rv_pkg::alu_or;
            default: return rv_pkg::alu_and;
        endcase
    endfunction

    logic [rv_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'b0};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (instr.r.opcode)
            rv_pkg::opc_op: begin
                ctrl.regwr  = 1'b1;
                ctrl.alu_op = alu_sel(instr.r.funct3, instr.r.funct7[5]);
            end
            rv_pkg::opc_op_imm: begin
                ctrl.regwr  = 1'b1;
                ctrl.bsrc   = rv_pkg::bsrc_imm;
                // only srai uses the alternate encoding here.
                ctrl.alu_op = alu_sel(instr.i.funct3,
                                      instr.i.funct3 == 3'b101 && instr.r.funct7[5]);
                imm         = imm_i;
            end
            rv_pkg::opc_lui: begin
                ctrl.regwr  = 1'b1;
                ctrl.bsrc   = rv_pkg::bsrc_imm;
                ctrl.alu_op = rv_pkg::alu_pass_b;
                imm         = imm_u;
            end
            rv_pkg::opc_auipc: begin
                ctrl.regwr = 1'b1;
                ctrl.asrc  = rv_pkg::asrc_pc;
                ctrl.bsrc  = rv_pkg::bsrc_imm;
                imm        = imm_u;
            end
            rv_pkg::opc_load: begin
                if (instr.i.funct3 == 3'b010) begin
                    ctrl.regwr      = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                    ctrl.bsrc       = rv_pkg::bsrc_imm;
                    imm             = imm_i;
                end
            end
            rv_pkg::opc_store: begin
                if (instr.s.funct3 == 3'b010) begin
                    ctrl.memwr = 1'b1;
                    ctrl.bsrc  = rv_pkg::bsrc_imm;
                    imm        = imm_s;
                end
            end
            rv_pkg::opc_branch: begin
                imm = imm_b;
                case (instr.b.funct3)
                    3'b000:  ctrl.branch = rv_pkg::br_eq;
                    3'b001:  ctrl.branch = rv_pkg::br_ne;
                    3'b100:  ctrl.branch = rv_pkg::br_lt;
                    3'b101:  ctrl.branch = rv_pkg::br_ge;
                    3'b110:  ctrl.branch = rv_pkg::br_ltu;
                    3'b111:  ctrl.branch = rv_pkg::br_geu;
                    default: ctrl.branch = rv_pkg::br_none;
                endcase
            end
            rv_pkg::opc_jal, rv_pkg::opc_jalr: begin
                // link value is pc + 4.
                ctrl.regwr  = 1'b1;
                ctrl.asrc   = rv_pkg::asrc_pc;
                ctrl.bsrc   = rv_pkg::bsrc_four;
                ctrl.branch = (instr.r.opcode == rv_pkg::opc_jal) ? rv_pkg::br_jal
                                                                 : rv_pkg::br_jalr;
                imm         = (instr.r.opcode == rv_pkg::opc_jal) ? imm_j : imm_i;
            end
            default: ;
        endcase
    end

endmodule

//--- design/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [rv_pkg::xlen-1:0]       rs1_data,
    output logic [rv_pkg::xlen-1:0]       rs2_data,
    input  logic                          wr_en,
    input  logic [rv_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [rv_pkg::xlen-1:0]       wr_data
);

    // x0 has no storage.
    logic [rv_pkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle writes bypass to the read ports.
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

    // a written value is read back from storage once the write is done.
    a_write_lands: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_en && wr_addr != '0) ##1 (!wr_en && rs1_addr == $past(wr_addr)) |->
            rs1_data == $past(wr_data));

endmodule

//--- design/execute.sv
`timescale 1ns/1ps

module execute (
    input  rv_pkg::id_ex_t          id_ex,
    input  rv_pkg::fwd_e            fwd_a,
    input  rv_pkg::fwd_e            fwd_b,
    input  logic [rv_pkg::xlen-1:0] mem_result,
    input  logic [rv_pkg::xlen-1:0] wb_result,
    output rv_pkg::ex_mem_t         ex_mem
);

    logic [rv_pkg::xlen-1:0] rs1_val, rs2_val, op_a, op_b, alu_out;
    logic                    unsigned_cmp;

    always_comb begin
        case (fwd_a)
            rv_pkg::fwd_mem: rs1_val = mem_result;
            rv_pkg::fwd_wb:  rs1_val = wb_result;
            default:         rs1_val = id_ex.rs1_val;
        endcase
        case (fwd_b)
            rv_pkg::fwd_mem: rs2_val = mem_result;
            rv_pkg::fwd_wb:  rs2_val = wb_result;
            default:         rs2_val = id_ex.rs2_val;
        endcase
    end

    assign op_a = (id_ex.ctrl.asrc == rv_pkg::asrc_pc) ? id_ex.pc : rs1_val;
    assign op_b = (id_ex.ctrl.bsrc == rv_pkg::bsrc_imm)  ? id_ex.imm :
                  (id_ex.ctrl.bsrc == rv_pkg::bsrc_four) ? 32'd4 : rs2_val;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            rv_pkg::alu_add:    alu_out = op_a + op_b;
            rv_pkg::alu_sub:    alu_out = op_a - op_b;
            rv_pkg::alu_and:    alu_out = op_a & op_b;
            rv_pkg::alu_or:     alu_out = op_a | op_b;
            rv_pkg::alu_xor:    alu_out = op_a ^ op_b;
            rv_pkg::alu_slt:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu:   alu_out = {31'b0, op_a < op_b};
            rv_pkg::alu_sll:    alu_out = op_a << op_b[4:0];
            rv_pkg::alu_srl:    alu_out = op_a >> op_b[4:0];
            rv_pkg::alu_sra:    alu_out = $signed(op_a) >>> op_b[4:0];
            rv_pkg::alu_pass_b: alu_out = op_b;
            default:            alu_out = '0;
        endcase
    end

    assign unsigned_cmp = id_ex.ctrl.branch == rv_pkg::br_ltu ||
                          id_ex.ctrl.branch == rv_pkg::br_geu;

    always_comb begin
        ex_mem.alu_result = alu_out;
        ex_mem.rs2_val    = rs2_val;
        ex_mem.target_pc  = id_ex.pc + id_ex.imm;
        // jalr clears bit 0 of the target.
        ex_mem.target_rs1 = (rs1_val + id_ex.imm) & ~32'd1;
        ex_mem.less       = unsigned_cmp ? (rs1_val < rs2_val)
                                         : ($signed(rs1_val) < $signed(rs2_val));
        ex_mem.zero       = rs1_val == rs2_val;
        ex_mem.rd         = id_ex.rd;
        ex_mem.ctrl       = id_ex.ctrl;
    end

endmodule

//--- design/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic [rv_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] id_rs2,
    input  logic [rv_pkg::reg_addr_w-1:0] ex_rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] ex_rs2,
    input  logic [rv_pkg::reg_addr_w-1:0] ex_rd,
    input  logic                          ex_is_load,
    input  logic [rv_pkg::reg_addr_w-1:0] mem_rd,
    input  logic                          mem_regwr,
    input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    input  logic                          wb_regwr,
    input  logic                          taken,
    output rv_pkg::fwd_e                  fwd_a,
    output rv_pkg::fwd_e                  fwd_b,
    output logic                          pc_hold,
    output rv_pkg::stage_ctl_e            if_id_ctl,
    output rv_pkg::stage_ctl_e            id_ex_ctl,
    output rv_pkg::stage_ctl_e            ex_mem_ctl
);

    logic load_use;

    // the younger result in memory wins over writeback.
    function automatic rv_pkg::fwd_e fwd_sel(input logic [rv_pkg::reg_addr_w-1:0] rs);
        if (mem_regwr && mem_rd != '0 && mem_rd == rs) begin
            return rv_pkg::fwd_mem;
        end else if (wb_regwr && wb_rd != '0 && wb_rd == rs) begin
            return rv_pkg::fwd_wb;
        end
        return rv_pkg::fwd_reg;
    endfunction

    assign load_use = ex_is_load && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

    // a redirect must never be held off by a stall.
    always_comb begin
        fwd_a      = fwd_sel(ex_rs1);
        fwd_b      = fwd_sel(ex_rs2);
        pc_hold    = 1'b0;
        if_id_ctl  = rv_pkg::ctl_run;
        id_ex_ctl  = rv_pkg::ctl_run;
        ex_mem_ctl = rv_pkg::ctl_run;
        if (taken) begin
            if_id_ctl  = rv_pkg::ctl_flush;
            id_ex_ctl  = rv_pkg::ctl_flush;
            ex_mem_ctl = rv_pkg::ctl_flush;
        end else if (load_use) begin
            pc_hold   = 1'b1;
            if_id_ctl = rv_pkg::ctl_pause;
            id_ex_ctl = rv_pkg::ctl_flush;
        end
    end

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  logic [rv_pkg::xlen-1:0] imem_data,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    output logic                    dmem_we,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output logic [rv_pkg::xlen-1:0] dbg_pc
);

    logic [rv_pkg::xlen-1:0] pc, pc_next, target, wb_data;
    logic [rv_pkg::xlen-1:0] dec_imm, rs1_data, rs2_data;
    logic                    taken, pc_hold;

    rv_pkg::if_id_t     if_id_d, if_id_q;
    rv_pkg::id_ex_t     id_ex_d, id_ex_q;
    rv_pkg::ex_mem_t    ex_mem_d, ex_mem_q;
    rv_pkg::mem_wb_t    mem_wb_d, mem_wb_q;
    rv_pkg::rv_instr_u  dec_instr;
    rv_pkg::ctrl_t      dec_ctrl;
    rv_pkg::fwd_e       fwd_a, fwd_b;
    rv_pkg::stage_ctl_e if_id_ctl, id_ex_ctl, ex_mem_ctl;

    // fetch.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= rv_pkg::reset_pc;
        end else if (!pc_hold) begin
            pc <= pc_next;
        end
    end

    assign imem_addr = pc;
    assign dbg_pc    = pc;
    assign pc_next   = taken ? target : pc + 32'd4;

    always_comb begin
        if_id_d.pc    = pc;
        if_id_d.instr = imem_data;
    end

    stage_reg #(.payload_t(rv_pkg::if_id_t)) u_if_id (
        .clk, .rst_n, .ctl(if_id_ctl), .d(if_id_d), .q(if_id_q)
    );

    // decode. a flushed slot holds all zeros and issues as a nop.
    assign dec_instr = (if_id_q.instr == '0) ? rv_pkg::nop_instr : if_id_q.instr;

    decoder u_decoder (.instr(dec_instr), .ctrl(dec_ctrl), .imm(dec_imm));

    regfile u_regfile (
        .clk,
        .rst_n,
        .rs1_addr (dec_instr.r.rs1),
        .rs2_addr (dec_instr.r.rs2),
        .rs1_data,
        .rs2_data,
        .wr_en    (mem_wb_q.regwr),
        .wr_addr  (mem_wb_q.rd),
        .wr_data  (wb_data)
    );

    always_comb begin
        id_ex_d.pc      = if_id_q.pc;
        id_ex_d.rs1_val = rs1_data;
        id_ex_d.rs2_val = rs2_data;
        id_ex_d.imm     = dec_imm;
        id_ex_d.rs1     = dec_instr.r.rs1;
        id_ex_d.rs2     = dec_instr.r.rs2;
        id_ex_d.rd      = dec_instr.r.rd;
        id_ex_d.ctrl    = dec_ctrl;
    end

    stage_reg #(.payload_t(rv_pkg::id_ex_t)) u_id_ex (
        .clk, .rst_n, .ctl(id_ex_ctl), .d(id_ex_d), .q(id_ex_q)
    );

    execute u_execute (
        .id_ex      (id_ex_q),
        .fwd_a,
        .fwd_b,
        .mem_result (ex_mem_q.alu_result),
        .wb_result  (wb_data),
        .ex_mem     (ex_mem_d)
    );

    stage_reg #(.payload_t(rv_pkg::ex_mem_t)) u_ex_mem (
        .clk, .rst_n, .ctl(ex_mem_ctl), .d(ex_mem_d), .q(ex_mem_q)
    );

    // memory stage and branch resolution.
    assign dmem_addr  = ex_mem_q.alu_result;
    assign dmem_wdata = ex_mem_q.rs2_val;
    assign dmem_we    = ex_mem_q.ctrl.memwr;

    always_comb begin
        case (ex_mem_q.ctrl.branch)
            rv_pkg::br_eq:                 taken = ex_mem_q.zero;
            rv_pkg::br_ne:                 taken = !ex_mem_q.zero;
            rv_pkg::br_lt, rv_pkg::br_ltu: taken = ex_mem_q.less;
            rv_pkg::br_ge, rv_pkg::br_geu: taken = !ex_mem_q.less;
            rv_pkg::br_jal, rv_pkg::br_jalr: taken = 1'b1;
            default:                       taken = 1'b0;
        endcase
    end

    assign target = (ex_mem_q.ctrl.branch == rv_pkg::br_jalr) ? ex_mem_q.target_rs1
                                                               : ex_mem_q.target_pc;

    always_comb begin
        mem_wb_d.alu_result = ex_mem_q.alu_result;
        mem_wb_d.load_data  = dmem_rdata;
        mem_wb_d.rd         = ex_mem_q.rd;
        mem_wb_d.regwr      = ex_mem_q.ctrl.regwr;
        mem_wb_d.mem_to_reg = ex_mem_q.ctrl.mem_to_reg;
    end

    stage_reg #(.payload_t(rv_pkg::mem_wb_t)) u_mem_wb (
        .clk, .rst_n, .ctl(rv_pkg::ctl_run), .d(mem_wb_d), .q(mem_wb_q)
    );

    // writeback.
    assign wb_data = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;

    hazard_unit u_hazard_unit (
        .id_rs1     (dec_instr.r.rs1),
        .id_rs2     (dec_instr.r.rs2),
        .ex_rs1     (id_ex_q.rs1),
        .ex_rs2     (id_ex_q.rs2),
        .ex_rd      (id_ex_q.rd),
        .ex_is_load (id_ex_q.ctrl.mem_to_reg),
        .mem_rd     (ex_mem_q.rd),
        .mem_regwr  (ex_mem_q.ctrl.regwr),
        .wb_rd      (mem_wb_q.rd),
        .wb_regwr   (mem_wb_q.regwr),
        .taken,
        .fwd_a,
        .fwd_b,
        .pc_hold,
        .if_id_ctl,
        .id_ex_ctl,
        .ex_mem_ctl
    );

    a_dmem_we_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(dmem_we));

endmodule

//--- tb/tb_core.sv
`timescale 1ns/1ps

module tb_core;

    localparam int test_count      = 5;
    // each program finishes in a few hundred cycles including reset.
    localparam int cycles_per_test = 1000;
    localparam int watchdog_cycles = test_count * cycles_per_test;
    localparam int done_word       = 'h100 >> 2;

    localparam int opc_op_imm = 'h13;
    localparam int opc_lui    = 'h37;
    localparam int opc_auipc  = 'h17;
    localparam int opc_load   = 'h03;
    localparam int opc_jalr   = 'h67;

    // add sub sll slt sltu xor srl sra or and.
    localparam int alu_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    localparam int alu_f7 [10] = '{0, 'h20, 0, 0, 0, 0, 0, 'h20, 0, 0};
    localparam int br_f3 [6]   = '{0, 1, 4, 5, 6, 7};
    localparam int pair_rs1 [3] = '{1, 2, 1};
    localparam int pair_rs2 [3] = '{2, 1, 1};

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data = '0;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata = '0;
    logic [31:0] dbg_pc;

    logic [31:0] rom [0:255];
    logic [31:0] ram [0:255];
    logic [31:0] ram_init [0:255];
    logic        wr_pend = 1'b0;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    int          wr_ptr;
    int          seed = 34419;
    int          error_count = 0;

    rv_core u_dut (
        .clk,
        .rst_n,
        .imem_addr,
        .imem_data,
        .dmem_addr,
        .dmem_wdata,
        .dmem_we,
        .dmem_rdata,
        .dbg_pc
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // a store seen in one cycle lands in the RAM at the next edge.
    always @(posedge clk) begin
        #1;
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                ram[i] = ram_init[i];
            end
            wr_pend = 1'b0;
        end else if (wr_pend) begin
            ram[wr_addr[9:2]] = wr_data;
        end
        wr_pend    = dmem_we;
        wr_addr    = dmem_addr;
        wr_data    = dmem_wdata;
        imem_data  = rom[imem_addr[9:2]];
        dmem_rdata = ram[dmem_addr[9:2]];
    end

    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input int imm, input int rd, input int opc);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic logic [31:0] alu_expect(input int k, input logic [31:0] a,
                                               input logic [31:0] b);
        case (k)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[4:0];
            3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4:       return (a < b) ? 32'd1 : 32'd0;
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return $signed(a) >>> b[4:0];
            8:       return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_expect(input int f3, input logic [31:0] x,
                                           input logic [31:0] y);
        case (f3)
            0:       return x == y;
            1:       return x != y;
            4:       return $signed(x) < $signed(y);
            5:       return $signed(x) >= $signed(y);
            6:       return x < y;
            default: return x >= y;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: expected %08h, actual %08h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic emit(input logic [31:0] instr);
        rom[wr_ptr] = instr;
        wr_ptr++;
    endtask

    task automatic load_const(input int rd, input logic [31:0] value);
        logic [31:0] upper;
        // addi sign-extends, so round the upper part.
        upper = (value + 32'h800) >> 12;
        emit(u_type(upper, rd, opc_lui));
        emit(i_type(value, rd, 0, rd, opc_op_imm));
    endtask

    task automatic store_word(input int rs2, input int addr);
        emit(s_type(addr, rs2, 0));
    endtask

    task automatic begin_program();
        int i;
        @(posedge clk);
        #1;
        rst_n  = 1'b0;
        wr_ptr = 0;
        for (i = 0; i < 256; i++) begin
            // addi x0, x0, i is harmless if fetched.
            rom[i]      = i_type(i, 0, 0, 0, opc_op_imm);
            ram_init[i] = 32'h5a5a_0000 | i;
        end
    endtask

    task automatic run_program();
        emit(i_type(1, 0, 0, 31, opc_op_imm));
        store_word(31, 'h100);
        emit(j_type(0, 0));
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check("reset pc", 32'h0, dbg_pc);
        while (ram[done_word] !== 32'd1) begin
            @(posedge clk);
        end
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        int          k;
        begin_program();
        a = $random(seed);
        b = $random(seed);
        load_const(1, a);
        load_const(2, b);
        for (k = 0; k < 10; k++) begin
            emit(r_type(alu_f7[k], 2, 1, alu_f3[k], 3));
            store_word(3, 'h200 + 4 * k);
        end
        run_program();
        for (k = 0; k < 10; k++) begin
            check($sformatf("alu op %0d", k), alu_expect(k, a, b), ram[('h200 >> 2) + k]);
        end
    endtask

    task automatic test_forwarding();
        logic [31:0] r [1:8];
        int          i;
        begin_program();
        r[1] = $random(seed);
        r[2] = $random(seed);
        load_const(1, r[1]);
        load_const(2, r[2]);
        for (i = 3; i <= 8; i++) begin
            emit(r_type(0, i - 2, i - 1, 0, i));
            r[i] = r[i - 1] + r[i - 2];
        end
        store_word(8, 'h240);
        store_word(7, 'h244);
        run_program();
        check("forward chain", r[8], ram['h240 >> 2]);
        check("forward chain prev", r[7], ram['h244 >> 2]);
    endtask

    task automatic test_load_use();
        logic [31:0] w;
        logic [31:0] v;
        logic [31:0] u;
        begin_program();
        w = $random(seed);
        v = $random(seed);
        u = $random(seed);
        ram_init['h300 >> 2] = v;
        ram_init['h304 >> 2] = u;
        load_const(1, w);
        emit(i_type('h300, 0, 2, 2, opc_load));
        emit(r_type(0, 1, 2, 0, 3));
        store_word(3, 'h280);
        emit(i_type('h304, 0, 2, 4, opc_load));
        emit(r_type(0, 4, 1, 0, 5));
        store_word(5, 'h284);
        // store then reload, the loaded value goes straight to a store.
        store_word(1, 'h308);
        emit(i_type('h308, 0, 2, 6, opc_load));
        store_word(6, 'h28c);
        run_program();
        check("load use rs1", v + w, ram['h280 >> 2]);
        check("load use rs2", w + u, ram['h284 >> 2]);
        check("load after store", w, ram['h28c >> 2]);
    endtask

    task automatic test_branches();
        logic [31:0] val [1:2];
        logic        taken;
        int          n;
        int          p;
        begin_program();
        val[1] = $random(seed);
        val[2] = $random(seed);
        if (val[2] == val[1]) begin
            val[2] = ~val[1];
        end
        load_const(1, val[1]);
        load_const(2, val[2]);
        for (n = 0; n < 6; n++) begin
            for (p = 0; p < 3; p++) begin
                emit(i_type('h55, 0, 0, 10, opc_op_imm));
                // taken skips the addi that would overwrite the marker.
                emit(b_type(8, pair_rs2[p], pair_rs1[p], br_f3[n]));
                emit(i_type('h77, 0, 0, 10, opc_op_imm));
                store_word(10, 'h200 + 4 * (3 * n + p));
            end
        end
        run_program();
        for (n = 0; n < 6; n++) begin
            for (p = 0; p < 3; p++) begin
                taken = branch_expect(br_f3[n], val[pair_rs1[p]], val[pair_rs2[p]]);
                check($sformatf("branch f3 %0d pair %0d", br_f3[n], p),
                      taken ? 32'h55 : 32'h77, ram[('h200 >> 2) + 3 * n + p]);
            end
        end
    endtask

    task automatic test_jumps();
        int jal_at;
        int auipc_at;
        begin_program();
        emit(i_type('h11, 0, 0, 6, opc_op_imm));
        jal_at = wr_ptr * 4;
        emit(j_type(12, 5));
        emit(i_type('h33, 0, 0, 6, opc_op_imm));
        emit(i_type('h34, 0, 0, 6, opc_op_imm));
        store_word(5, 'h2c0);
        auipc_at = wr_ptr * 4;
        emit(u_type(0, 9, opc_auipc));
        // odd offset, the jump target drops bit 0.
        emit(i_type(17, 9, 0, 8, opc_jalr));
        emit(i_type('h35, 0, 0, 6, opc_op_imm));
        emit(i_type('h36, 0, 0, 6, opc_op_imm));
        store_word(8, 'h2c4);
        store_word(6, 'h2c8);
        store_word(9, 'h2cc);
        run_program();
        check("jal link", jal_at + 4, ram['h2c0 >> 2]);
        check("jalr link", auipc_at + 8, ram['h2c4 >> 2]);
        check("jump marker", 32'h11, ram['h2c8 >> 2]);
        check("auipc value", auipc_at, ram['h2cc >> 2]);
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, a program never finished",
                 watchdog_cycles);
        $display("Result: FAILED");
        $fatal(1, "simulation timed out");
    end

    initial begin
        rst_n = 1'b0;
        test_alu();
        test_forwarding();
        test_load_use();
        test_branches();
        test_jumps();
        if (error_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $fatal(1, "%0d checks failed", error_count);
        end
    end

endmodule

//--- sim.f
design/rv_pkg.sv
design/stage_reg.sv
design/decoder.sv
design/regfile.sv
design/execute.sv
design/hazard_unit.sv
design/rv_core.sv
tb/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core -Mdir obj_dir -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_core
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
